/* hdl/ddr_macros.svh */
// lane count, fall timing, field rows, step gaps, choreography length and score width
`ifndef DDR_MACROS_SVH
`define DDR_MACROS_SVH

// four lanes, one per arrow
`define NUM_LANES 4

// clocks between one-row moves of a falling block
`define FALL_TICK 4
`define TICK_W 2 // wide enough for FALL_TICK - 1

// field rows
`define Y_TOP 8'd20 // spawn row
`define Y_WINDOW 8'd75 // press window opens below this row
`define Y_BOTTOM 8'd90 // last row before a miss

// gap lengths in cycles, selected by a 2-bit gap code
`define GAP_0 40
`define GAP_1 24
`define GAP_2 80
`define GAP_3 36
`define GAP_CNT_W 7 // holds the longest gap

// choreography
`define STEP_COUNT 16
`define STEP_W 4 // step index width

// score register, two hex digits
`define SCORE_W 8

`endif

/* hdl/ddr_pkg.sv */
// lane and spawn types, choreography tables, seven-segment patterns and gap lookup
`include "ddr_macros.svh"

package ddr_pkg;

	typedef logic [1:0] laneIndex_t;
	typedef logic [1:0] gapCode_t;

	typedef struct packed {
		logic       valid; // one-cycle spawn pulse
		laneIndex_t lane;
	} spawn_t;

	typedef struct packed {
		logic key; // push button
		logic pad; // floor pad
	} laneInput_t;

	typedef struct packed {
		logic       active;
		logic       window; // press accepted
		logic       hit;
		logic       miss;
		logic [7:0] y; // current row
	} laneStatus_t;

	// leading pairs of the original step and timing strings
	localparam laneIndex_t CHOREO_LANE [`STEP_COUNT] = '{
		2'd1, 2'd1, 2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd3,
		2'd0, 2'd0, 2'd0, 2'd3, 2'd1, 2'd2, 2'd0, 2'd0
	};
	localparam gapCode_t CHOREO_GAP [`STEP_COUNT] = '{
		2'd3, 2'd0, 2'd3, 2'd2, 2'd0, 2'd2, 2'd1, 2'd3,
		2'd0, 2'd3, 2'd3, 2'd0, 2'd0, 2'd3, 2'd1, 2'd0
	};

	// active low, segment g in bit 6
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000,
		7'b001_1001, 7'b001_0010, 7'b000_0010, 7'b111_1000,
		7'b000_0000, 7'b001_1000, 7'b000_1000, 7'b000_0011,
		7'b100_0110, 7'b010_0001, 7'b000_0110, 7'b000_1110
	};

	function automatic logic [`GAP_CNT_W-1:0] gapCycles(input gapCode_t code);
		case (code)
			2'd0: gapCycles = `GAP_CNT_W'(`GAP_0);
			2'd1: gapCycles = `GAP_CNT_W'(`GAP_1);
			2'd2: gapCycles = `GAP_CNT_W'(`GAP_2);
			default: gapCycles = `GAP_CNT_W'(`GAP_3);
		endcase
	endfunction

endpackage

/* hdl/stepSequencer.sv */
// step sequencer: walks the choreography and fires one spawn pulse per step
`timescale 1ns/100ps
`include "ddr_macros.svh"

module stepSequencer
(
	input  logic            clock,
	input  logic            resetn,
	output ddr_pkg::spawn_t spawn
);

	logic [`STEP_W-1:0]    stepIndex; // current choreography step
	logic [`GAP_CNT_W-1:0] gapCount; // cycles since last spawn
	logic [`GAP_CNT_W-1:0] gapLength;
	logic                  gapDone;
	logic                  lastStep;
	logic                  spawnValid;
	ddr_pkg::laneIndex_t   spawnLane;

	// gap of the step that is waiting to fire
	assign gapLength = ddr_pkg::gapCycles(ddr_pkg::CHOREO_GAP[stepIndex]);
	assign gapDone = (gapCount == gapLength - 1'b1);
	assign lastStep = (stepIndex == `STEP_W'(`STEP_COUNT - 1));

	always_ff @(posedge clock)
	begin
		if (resetn)
		begin
			stepIndex <= '0;
			gapCount <= '0;
		end
		else if (gapDone)
		begin
			gapCount <= '0; // restart for the next step
			if (lastStep)
			begin
				stepIndex <= '0; // wrap to the top of the table
			end
			else
			begin
				stepIndex <= stepIndex + 1'b1;
			end
		end
		else
		begin
			gapCount <= gapCount + 1'b1;
		end
	end

	// registered pulse, so it stays low in the cycle after reset
	always_ff @(posedge clock)
	begin
		if (resetn)
		begin
			spawnValid <= 1'b0;
		end
		else
		begin
			spawnValid <= gapDone;
		end
	end

	// lane only matters alongside valid
	always_ff @(posedge clock)
	begin
		if (gapDone)
		begin
			spawnLane <= ddr_pkg::CHOREO_LANE[stepIndex];
		end
	end

	assign spawn.valid = spawnValid;
	assign spawn.lane = spawnLane;

	// gaps are far longer than one cycle, so a pulse never repeats back to back
	spawnSinglePulse: assert property (@(posedge clock) disable iff (resetn)
		spawn.valid |=> !spawn.valid)
		else $error("spawn valid held for two cycles");

endmodule

/* hdl/fallingLane.sv */
// falling lane: block row, fall timer, press window and hit/miss pulses
`timescale 1ns/100ps
`include "ddr_macros.svh"

module fallingLane
#(
	parameter int LANE_ID = 0
)
(
	input  logic                 clock,
	input  logic                 resetn,
	input  ddr_pkg::spawn_t      spawn,
	input  ddr_pkg::laneInput_t  press,
	output ddr_pkg::laneStatus_t status
);

	logic              active; // block is falling
	logic [7:0]        row;
	logic [`TICK_W-1:0] tickCount; // cycles since last move
	logic              hitPulse;
	logic              missPulse;
	logic              window;
	logic              pressed;
	logic              spawnHere;
	logic              tickDone;

	assign spawnHere = spawn.valid && (spawn.lane == ddr_pkg::laneIndex_t'(LANE_ID));
	assign pressed = press.key | press.pad; // either input counts
	assign window = active && (row > `Y_WINDOW);
	assign tickDone = (tickCount == `TICK_W'(`FALL_TICK - 1));

	always_ff @(posedge clock)
	begin
		if (resetn)
		begin
			active <= 1'b0;
			row <= `Y_TOP;
			tickCount <= '0;
			hitPulse <= 1'b0;
			missPulse <= 1'b0;
		end
		else
		begin
			hitPulse <= 1'b0;
			missPulse <= 1'b0;
			if (!active)
			begin
				if (spawnHere)
				begin
					active <= 1'b1;
					row <= `Y_TOP;
					tickCount <= '0;
				end
			end
			else if (window && pressed)
			begin
				hitPulse <= 1'b1; // caught in time
				active <= 1'b0;
				row <= `Y_TOP;
			end
			else if (tickDone)
			begin
				tickCount <= '0;
				if (row == `Y_BOTTOM)
				begin
					missPulse <= 1'b1; // fell off the field
					active <= 1'b0;
					row <= `Y_TOP;
				end
				else
				begin
					row <= row + 1'b1;
				end
			end
			else
			begin
				tickCount <= tickCount + 1'b1;
			end
		end
	end

	assign status.active = active;
	assign status.window = window;
	assign status.hit = hitPulse;
	assign status.miss = missPulse;
	assign status.y = row;

	hitMissExclusive: assert property (@(posedge clock) disable iff (resetn)
		!(status.hit && status.miss))
		else $error("lane %0d hit and miss together", LANE_ID);

	windowNeedsActive: assert property (@(posedge clock) disable iff (resetn)
		status.window |-> status.active)
		else $error("lane %0d window open while idle", LANE_ID);

endmodule

/* hdl/scoreKeeper.sv */
// score keeper: hit counter with clear and two seven-segment digits
`timescale 1ns/100ps
`include "ddr_macros.svh"

module scoreKeeper
(
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 clearScore,
	input  ddr_pkg::laneStatus_t laneState [`NUM_LANES],
	output logic [`SCORE_W-1:0]  score,
	output logic [6:0]           segOnes,
	output logic [6:0]           segTens
);

	localparam int HIT_W = $clog2(`NUM_LANES + 1);

	logic [HIT_W-1:0] hitCount; // hits seen this cycle

	// several lanes can hit in the same cycle
	always_comb
	begin
		hitCount = '0;
		for (int i = 0; i < `NUM_LANES; i++)
		begin
			hitCount = hitCount + HIT_W'(laneState[i].hit);
		end
	end

	always_ff @(posedge clock)
	begin
		if (resetn)
		begin
			score <= '0;
		end
		else if (clearScore)
		begin
			score <= '0; // clear wins over hits
		end
		else
		begin
			score <= score + `SCORE_W'(hitCount); // wraps at 256
		end
	end

	assign segOnes = ddr_pkg::SEG_TABLE[score[3:0]];
	assign segTens = ddr_pkg::SEG_TABLE[score[7:4]];

	// score only moves on the edge after a lane hit or a clear
	scoreStable: assert property (@(posedge clock) disable iff (resetn)
		(!clearScore && hitCount == '0) |=> $stable(score))
		else $error("score changed without a hit or clear");

endmodule

/* hdl/danceGame.sv */
// top level: step sequencer, generated falling lanes and score keeper
`timescale 1ns/100ps
`include "ddr_macros.svh"

module danceGame
(
	input  logic                 clock,
	input  logic                 resetn,
	input  ddr_pkg::laneInput_t  laneIn [`NUM_LANES],
	input  logic                 clearScore,
	output ddr_pkg::laneStatus_t laneState [`NUM_LANES],
	output logic [`SCORE_W-1:0]  score,
	output logic [6:0]           segOnes,
	output logic [6:0]           segTens
);

	ddr_pkg::spawn_t spawnBus; // shared by every lane

	stepSequencer sequencerInst
	(
		.clock  (clock),
		.resetn (resetn),
		.spawn  (spawnBus)
	);

	genvar laneNum;
	generate
		for (laneNum = 0; laneNum < `NUM_LANES; laneNum++)
		begin : lanes
			fallingLane #(.LANE_ID(laneNum)) laneInst
			(
				.clock  (clock),
				.resetn (resetn),
				.spawn  (spawnBus),
				.press  (laneIn[laneNum]),
				.status (laneState[laneNum])
			);
		end
	endgenerate

	scoreKeeper scoreInst
	(
		.clock      (clock),
		.resetn     (resetn),
		.clearScore (clearScore),
		.laneState  (laneState),
		.score      (score),
		.segOnes    (segOnes),
		.segTens    (segTens)
	);

endmodule

/* dv/scoreChecker.sv */
// reference model of sequencer, lanes and score, compared with the DUT outputs every cycle
`timescale 1ns/100ps
`include "ddr_macros.svh"

module scoreChecker
(
	input  logic                 clock,
	input  logic                 resetn,
	input  ddr_pkg::laneInput_t  laneIn [`NUM_LANES],
	input  logic                 clearScore,
	input  ddr_pkg::laneStatus_t laneState [`NUM_LANES],
	input  logic [`SCORE_W-1:0]  score,
	input  logic [6:0]           segOnes,
	input  logic [6:0]           segTens,
	output int                   checkCount,
	output int                   errorCount,
	output int                   testCount,
	output int                   failedTests
);

	int         checks = 0;
	int         errors = 0;
	int         tests = 0;
	int         failed = 0;
	int         cycle = 0;
	logic       modelValid = 1'b0; // no prediction before the first edge
	logic       inReset = 1'b1;
	int         elapsed; // edges since the last spawn
	int         step;
	logic       spawnValid;
	int         spawnLane;
	logic       active [`NUM_LANES];
	logic [7:0] row [`NUM_LANES];
	int         tick [`NUM_LANES];
	logic       hit [`NUM_LANES];
	logic       miss [`NUM_LANES];
	logic [7:0] expScore;
	int         errorsAtSpawn [`NUM_LANES];
	int         spawnCycle [`NUM_LANES];

	assign checkCount = checks;
	assign errorCount = errors;
	assign testCount = tests;
	assign failedTests = failed;

	function automatic int gapLength(input logic [1:0] code);
		case (code)
			2'd0: return `GAP_0;
			2'd1: return `GAP_1;
			2'd2: return `GAP_2;
			default: return `GAP_3;
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [31:0] value,
		input logic [31:0] expected);
		checks++;
		if (value !== expected)
		begin
			errors++;
			$display("[FAIL] cycle %0d %s: got %0h, expected %0h", cycle, name, value, expected);
		end
	endtask

	task automatic reportBlock(input int lane);
		logic clean;
		clean = (errors == errorsAtSpawn[lane]);
		tests++;
		if (!clean)
		begin
			failed++;
		end
		$display("lane %0d block from cycle %0d ended by %s: %s", lane, spawnCycle[lane],
			hit[lane] ? "hit" : "miss", clean ? "pass" : "failed");
	endtask

	// compare at the falling edge, then predict the next rising edge
	always @(negedge clock)
	begin
		int hits;
		cycle++;
		if (modelValid)
		begin
			for (int l = 0; l < `NUM_LANES; l++)
			begin
				compareValue($sformatf("laneState[%0d].active", l), 32'(laneState[l].active),
					32'(active[l]));
				compareValue($sformatf("laneState[%0d].window", l), 32'(laneState[l].window),
					32'(active[l] && (row[l] > `Y_WINDOW)));
				compareValue($sformatf("laneState[%0d].hit", l), 32'(laneState[l].hit), 32'(hit[l]));
				compareValue($sformatf("laneState[%0d].miss", l), 32'(laneState[l].miss),
					32'(miss[l]));
				compareValue($sformatf("laneState[%0d].y", l), 32'(laneState[l].y), 32'(row[l]));
			end
			compareValue("score", 32'(score), 32'(expScore));
			compareValue("segOnes", 32'(segOnes), 32'(ddr_pkg::SEG_TABLE[expScore[3:0]]));
			compareValue("segTens", 32'(segTens), 32'(ddr_pkg::SEG_TABLE[expScore[7:4]]));
			for (int l = 0; l < `NUM_LANES; l++)
			begin
				if (hit[l] || miss[l])
				begin
					reportBlock(l);
				end
			end
			if (inReset && !resetn)
			begin
				tests++;
				if (errors != 0)
				begin
					failed++;
				end
				$display("reset state at cycle %0d: %s", cycle, (errors == 0) ? "pass" : "failed");
				inReset = 1'b0;
			end
		end
		if (resetn)
		begin
			elapsed = 0;
			step = 0;
			spawnValid = 1'b0;
			spawnLane = 0;
			expScore = '0;
			inReset = 1'b1;
			for (int l = 0; l < `NUM_LANES; l++)
			begin
				active[l] = 1'b0;
				row[l] = `Y_TOP;
				tick[l] = 0;
				hit[l] = 1'b0;
				miss[l] = 1'b0;
			end
		end
		else
		begin
			hits = 0;
			for (int l = 0; l < `NUM_LANES; l++)
			begin
				hits = hits + (hit[l] ? 1 : 0); // this cycle's pulses
			end
			expScore = clearScore ? 8'd0 : expScore + 8'(hits);
			for (int l = 0; l < `NUM_LANES; l++)
			begin
				hit[l] = 1'b0;
				miss[l] = 1'b0;
				if (!active[l])
				begin
					if (spawnValid && spawnLane == l)
					begin
						active[l] = 1'b1;
						row[l] = `Y_TOP;
						tick[l] = 0;
						errorsAtSpawn[l] = errors;
						spawnCycle[l] = cycle;
					end
				end
				else if (row[l] > `Y_WINDOW && (laneIn[l].key || laneIn[l].pad))
				begin
					hit[l] = 1'b1;
					active[l] = 1'b0;
					row[l] = `Y_TOP;
				end
				else if (tick[l] == `FALL_TICK - 1)
				begin
					tick[l] = 0;
					if (row[l] == `Y_BOTTOM)
					begin
						miss[l] = 1'b1;
						active[l] = 1'b0;
						row[l] = `Y_TOP;
					end
					else
					begin
						row[l] = row[l] + 8'd1;
					end
				end
				else
				begin
					tick[l]++;
				end
			end
			elapsed++;
			spawnValid = 1'b0;
			if (elapsed == gapLength(ddr_pkg::CHOREO_GAP[step]))
			begin
				spawnValid = 1'b1; // seen by the lanes one edge later
				spawnLane = int'(ddr_pkg::CHOREO_LANE[step]);
				elapsed = 0;
				step = (step + 1) % `STEP_COUNT;
			end
		end
		modelValid = 1'b1;
	end

endmodule

/* dv/danceGame_tb.sv */
// testbench top: clock, reset, seeded random presses and clears, DUT, checker and timeout
`timescale 1ns/100ps
`include "ddr_macros.svh"

module danceGame_tb;

	localparam int FALL_CYCLES = (`Y_BOTTOM - `Y_TOP + 1) * `FALL_TICK + 2; // spawn to miss
	localparam int MARGIN = 200;

	logic                 clock = 1'b0;
	logic                 resetn;
	ddr_pkg::laneInput_t  laneIn [`NUM_LANES];
	logic                 clearScore;
	ddr_pkg::laneStatus_t laneState [`NUM_LANES];
	logic [`SCORE_W-1:0]  score;
	logic [6:0]           segOnes;
	logic [6:0]           segTens;

	int                   checkCount;
	int                   errorCount;
	int                   testCount;
	int                   failedTests;
	int                   cycleCount = 0;
	int                   cycleLimit = 0;
	int                   stimulusCycles;
	logic                 stimulusOn = 1'b0;
	ddr_pkg::laneStatus_t seen [`NUM_LANES] = '{default: '0}; // outputs taken mid-cycle
	logic                 wasActive [`NUM_LANES] = '{default: 1'b0};
	logic                 pressPlanned [`NUM_LANES] = '{default: 1'b0};
	logic [7:0]           pressRow [`NUM_LANES] = '{default: 8'd0};
	logic                 pending [`NUM_LANES];
	logic                 pressSent = 1'b0; // a press went out on the last edge

	danceGame dut_i
	(
		.clock      (clock),
		.resetn     (resetn),
		.laneIn     (laneIn),
		.clearScore (clearScore),
		.laneState  (laneState),
		.score      (score),
		.segOnes    (segOnes),
		.segTens    (segTens)
	);

	scoreChecker checkerInst
	(
		.clock       (clock),
		.resetn      (resetn),
		.laneIn      (laneIn),
		.clearScore  (clearScore),
		.laneState   (laneState),
		.score       (score),
		.segOnes     (segOnes),
		.segTens     (segTens),
		.checkCount  (checkCount),
		.errorCount  (errorCount),
		.testCount   (testCount),
		.failedTests (failedTests)
	);

	always #50 clock = ~clock; // 100 ns period

	// one pass over the step table
	function automatic int choreographyCycles();
		int total = 0;
		for (int k = 0; k < `STEP_COUNT; k++)
		begin
			case (ddr_pkg::CHOREO_GAP[k])
				2'd0: total += `GAP_0;
				2'd1: total += `GAP_1;
				2'd2: total += `GAP_2;
				default: total += `GAP_3;
			endcase
		end
		return total;
	endfunction

	function automatic logic anyPending();
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			if (pending[l])
			begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	always @(negedge clock)
	begin
		seen = laneState;
	end

	// per block: press in the window, press outside it, or leave it to miss
	always @(posedge clock)
	begin
		logic chord;
		logic pressNow;
		chord = stimulusOn && ($urandom_range(15) == 0); // press every planned open window at once
		pressNow = 1'b0;
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			if (seen[l].active && !wasActive[l])
			begin
				case ($urandom_range(2))
					0:
					begin
						pressPlanned[l] = 1'b1;
						pressRow[l] = `Y_WINDOW + 8'd1 + 8'($urandom_range(14));
					end
					1:
					begin
						pressPlanned[l] = 1'b1;
						pressRow[l] = `Y_TOP + 8'($urandom_range(55));
					end
					default: pressPlanned[l] = 1'b0;
				endcase
			end
			wasActive[l] = seen[l].active;
			laneIn[l] <= '0;
			if (stimulusOn && seen[l].active && pressPlanned[l] && ((seen[l].y == pressRow[l])
				|| (chord && seen[l].window)))
			begin
				laneIn[l] <= ddr_pkg::laneInput_t'(2'($urandom_range(3, 1))); // key, pad or both
				pressPlanned[l] = 1'b0;
				pressNow = 1'b1;
			end
		end
		// a clear right after a press can meet the hit on the same edge
		clearScore <= stimulusOn && ($urandom_range(pressSent ? 3 : 63) == 0);
		pressSent = pressNow;
	end

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Checks failed");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(90));
		resetn = 1'b1;
		clearScore = 1'b0;
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			laneIn[l] = '0;
			pending[l] = 1'b0;
		end
		stimulusCycles = 2 * choreographyCycles();
		cycleLimit = stimulusCycles + FALL_CYCLES + MARGIN;
		repeat (5) @(posedge clock);
		resetn <= 1'b0;
		stimulusOn <= 1'b1;
		repeat (stimulusCycles) @(posedge clock);
		stimulusOn <= 1'b0;
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			pending[l] = seen[l].active; // let blocks in flight run out
		end
		while (anyPending())
		begin
			@(negedge clock);
			for (int l = 0; l < `NUM_LANES; l++)
			begin
				if (!laneState[l].active)
				begin
					pending[l] = 1'b0;
				end
			end
		end
		repeat (2) @(negedge clock);
		@(posedge clock);
		$display("tests %0d, failed %0d, checks %0d, errors %0d", testCount, failedTests,
			checkCount, errorCount);
		if (errorCount == 0 && failedTests == 0 && checkCount > 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+hdl
hdl/ddr_pkg.sv
hdl/stepSequencer.sv
hdl/fallingLane.sv
hdl/scoreKeeper.sv
hdl/danceGame.sv
dv/scoreChecker.sv
dv/danceGame_tb.sv

/* Makefile */
# Verilator build and run for the rhythm game core

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= danceGame_tb
RTL_TOP   ?= danceGame
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
